// File: Bender.yml
package:
  name: rocache

sources:
  - hdl/rocache_pkg.sv
  - hdl/rocache_route.sv
  - hdl/rocache_lookup.sv
  - hdl/rocache_refill.sv
  - hdl/rocache_mem_arb.sv
  - hdl/rocache_top.sv
  - target: test
    files:
      - tb/rocache_assertions.sv
      - tb/rocache_tb.sv

// File: hdl/rocache_lookup.sv
`timescale 1ns/1ns
`default_nettype none

module rocache_lookup (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic               flush_req_i,
  output logic               flush_ack_o,
  input  logic               cache_req_i,
  input  rocache_pkg::addr_t cache_addr_i,
  output logic               cache_ack_o,
  output rocache_pkg::data_t cache_rdata_o,
  output logic               cache_err_o,
  output logic               fill_req_o,
  output rocache_pkg::addr_t fill_addr_o,
  input  logic               fill_ack_i,
  input  rocache_pkg::line_t fill_line_i,
  input  logic               fill_err_i
);
  import rocache_pkg::*;

  typedef enum logic [2:0] {
    L_IDLE, L_CMP, L_FILL, L_ACK, L_FLUSH, L_FDONE
  } state_e;

  state_e                state_q;
  logic [LINE_COUNT-1:0] valid_q;
  tag_t                  tag_mem [LINE_COUNT];
  line_t                 data_mem [LINE_COUNT];
  addr_t                 addr_q;
  data_t                 rdata_q;
  index_t                flush_idx_q;
  logic                  ack_q;
  logic                  err_q;
  logic                  fill_req_q;
  logic                  flush_ack_q;
  index_t                idx;
  tag_t                  tag;
  word_ofs_t             word;
  logic                  hit;

  assign idx  = addr_q[BYTE_OFS_W+WORD_OFS_W +: INDEX_W];
  assign tag  = addr_q[ADDR_W-1 -: TAG_W];
  assign word = addr_q[BYTE_OFS_W +: WORD_OFS_W];
  assign hit  = valid_q[idx] && (tag_mem[idx] == tag);

  // ----------------------------------------------------------
  // Control FSM
  // ----------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q     <= L_IDLE;
      valid_q     <= '0;
      flush_idx_q <= '0;
      ack_q       <= 1'b0;
      err_q       <= 1'b0;
      fill_req_q  <= 1'b0;
      flush_ack_q <= 1'b0;
    end else begin
      case (state_q)
        L_IDLE: begin
          if (flush_req_i) begin
            flush_idx_q <= '0;
            state_q     <= L_FLUSH;
          end else if (cache_req_i) begin
            state_q <= L_CMP;
          end
        end
        L_CMP: begin
          if (hit) begin
            err_q   <= 1'b0;
            ack_q   <= 1'b1;
            state_q <= L_ACK;
          end else begin
            fill_req_q <= 1'b1;
            state_q    <= L_FILL;
          end
        end
        L_FILL: begin
          if (fill_ack_i) begin
            // Failed refill keeps the line out of the cache
            valid_q[idx] <= !fill_err_i;
            err_q        <= fill_err_i;
            fill_req_q   <= 1'b0;
            ack_q        <= 1'b1;
            state_q      <= L_ACK;
          end
        end
        L_ACK: begin
          if (!cache_req_i && !fill_ack_i) begin
            ack_q   <= 1'b0;
            state_q <= L_IDLE;
          end
        end
        // One line per cycle
        L_FLUSH: begin
          valid_q[flush_idx_q] <= 1'b0;
          flush_idx_q          <= flush_idx_q + 1'b1;
          if (flush_idx_q == index_t'(LINE_COUNT - 1)) begin
            flush_ack_q <= 1'b1;
            state_q     <= L_FDONE;
          end
        end
        L_FDONE: begin
          if (!flush_req_i) begin
            flush_ack_q <= 1'b0;
            state_q     <= L_IDLE;
          end
        end
        default: state_q <= L_IDLE;
      endcase
    end
  end

  // Arrays and read data
  always_ff @(posedge clk_i) begin
    if (state_q == L_IDLE && cache_req_i) addr_q <= cache_addr_i;
    if (state_q == L_CMP) rdata_q <= data_mem[idx][word*DATA_W +: DATA_W];
    if (state_q == L_FILL && fill_ack_i) begin
      rdata_q <= fill_line_i[word*DATA_W +: DATA_W];
      if (!fill_err_i) begin
        data_mem[idx] <= fill_line_i;
        tag_mem[idx]  <= tag;
      end
    end
  end

  assign cache_ack_o   = ack_q;
  assign cache_rdata_o = rdata_q;
  assign cache_err_o   = err_q;
  assign fill_req_o    = fill_req_q;
  assign fill_addr_o   = {addr_q[ADDR_W-1:BYTE_OFS_W+WORD_OFS_W],
                          {(BYTE_OFS_W + WORD_OFS_W){1'b0}}};
  assign flush_ack_o   = flush_ack_q;

endmodule

`default_nettype wire

// File: hdl/rocache_mem_arb.sv
`timescale 1ns/1ns
`default_nettype none

module rocache_mem_arb (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic               byp_req_i,
  input  logic               byp_we_i,
  input  rocache_pkg::addr_t byp_addr_i,
  input  rocache_pkg::data_t byp_wdata_i,
  output logic               byp_ack_o,
  output rocache_pkg::data_t byp_rdata_o,
  output logic               byp_err_o,
  input  logic               rd_req_i,
  input  rocache_pkg::addr_t rd_addr_i,
  output logic               rd_ack_o,
  output rocache_pkg::data_t rd_rdata_o,
  output logic               rd_err_o,
  output logic               mem_req_o,
  output logic               mem_we_o,
  output rocache_pkg::addr_t mem_addr_o,
  output rocache_pkg::data_t mem_wdata_o,
  input  logic               mem_ack_i,
  input  rocache_pkg::data_t mem_rdata_i,
  input  logic               mem_err_i
);
  import rocache_pkg::*;

  logic busy_q;
  // High when the refill engine owns the port
  logic gnt_rd_q;
  logic gnt_req;

  assign gnt_req = gnt_rd_q ? rd_req_i : byp_req_i;

  // Grant lasts until both the client req and the memory ack are low
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      busy_q   <= 1'b0;
      gnt_rd_q <= 1'b0;
    end else if (!busy_q) begin
      if (rd_req_i || byp_req_i) begin
        busy_q   <= 1'b1;
        gnt_rd_q <= rd_req_i;
      end
    end else if (!gnt_req && !mem_ack_i) begin
      busy_q <= 1'b0;
    end
  end

  assign mem_req_o   = busy_q && gnt_req;
  assign mem_we_o    = !gnt_rd_q && byp_we_i;
  assign mem_addr_o  = gnt_rd_q ? rd_addr_i : byp_addr_i;
  assign mem_wdata_o = gnt_rd_q ? data_t'(0) : byp_wdata_i;

  assign byp_ack_o   = busy_q && !gnt_rd_q && mem_ack_i;
  assign rd_ack_o    = busy_q && gnt_rd_q && mem_ack_i;
  assign byp_rdata_o = mem_rdata_i;
  assign rd_rdata_o  = mem_rdata_i;
  assign byp_err_o   = !gnt_rd_q && mem_err_i;
  assign rd_err_o    = gnt_rd_q && mem_err_i;

endmodule

`default_nettype wire

// File: hdl/rocache_pkg.sv
`default_nettype none

package rocache_pkg;

  // ----------------------------------------------------------
  // Geometry
  // ----------------------------------------------------------
  localparam int unsigned ADDR_W     = 16;
  localparam int unsigned DATA_W     = 32;
  localparam int unsigned LINE_WORDS = 4;
  localparam int unsigned LINE_COUNT = 8;
  localparam int unsigned NUM_RULES  = 2;

  // Address split, low to high: byte, word, index, tag
  localparam int unsigned BYTE_OFS_W = $clog2(DATA_W / 8);
  localparam int unsigned WORD_OFS_W = $clog2(LINE_WORDS);
  localparam int unsigned INDEX_W    = $clog2(LINE_COUNT);
  localparam int unsigned TAG_W      = ADDR_W - INDEX_W - WORD_OFS_W - BYTE_OFS_W;

  // ----------------------------------------------------------
  // Shared types
  // ----------------------------------------------------------
  typedef logic [ADDR_W-1:0]            addr_t;
  typedef logic [DATA_W-1:0]            data_t;
  // Word 0 sits in the low bits
  typedef logic [LINE_WORDS*DATA_W-1:0] line_t;
  typedef logic [INDEX_W-1:0]           index_t;
  typedef logic [TAG_W-1:0]             tag_t;
  typedef logic [WORD_OFS_W-1:0]        word_ofs_t;

  typedef enum logic {
    PATH_BYPASS = 1'b0,
    PATH_CACHE  = 1'b1
  } path_e;

endpackage

`default_nettype wire

// File: hdl/rocache_refill.sv
`timescale 1ns/1ns
`default_nettype none

module rocache_refill (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic               fill_req_i,
  input  rocache_pkg::addr_t fill_addr_i,
  output logic               fill_ack_o,
  output rocache_pkg::line_t fill_line_o,
  output logic               fill_err_o,
  output logic               rd_req_o,
  output rocache_pkg::addr_t rd_addr_o,
  input  logic               rd_ack_i,
  input  rocache_pkg::data_t rd_rdata_i,
  input  logic               rd_err_i
);
  import rocache_pkg::*;

  typedef enum logic [1:0] {R_IDLE, R_REQ, R_REL, R_ACK} state_e;

  state_e    state_q;
  word_ofs_t word_q;
  line_t     line_q;
  logic      err_q;
  logic      rd_req_q;
  logic      fill_ack_q;

  // Word sequencer, one four-phase read per word
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q    <= R_IDLE;
      word_q     <= '0;
      err_q      <= 1'b0;
      rd_req_q   <= 1'b0;
      fill_ack_q <= 1'b0;
    end else begin
      case (state_q)
        R_IDLE: begin
          if (fill_req_i) begin
            word_q   <= '0;
            err_q    <= 1'b0;
            rd_req_q <= 1'b1;
            state_q  <= R_REQ;
          end
        end
        R_REQ: begin
          if (rd_ack_i) begin
            err_q    <= err_q | rd_err_i;
            rd_req_q <= 1'b0;
            state_q  <= R_REL;
          end
        end
        R_REL: begin
          if (!rd_ack_i) begin
            if (word_q == word_ofs_t'(LINE_WORDS - 1)) begin
              fill_ack_q <= 1'b1;
              state_q    <= R_ACK;
            end else begin
              word_q   <= word_q + 1'b1;
              rd_req_q <= 1'b1;
              state_q  <= R_REQ;
            end
          end
        end
        R_ACK: begin
          if (!fill_req_i) begin
            fill_ack_q <= 1'b0;
            state_q    <= R_IDLE;
          end
        end
        default: state_q <= R_IDLE;
      endcase
    end
  end

  // Line assembly
  always_ff @(posedge clk_i) begin
    if (state_q == R_REQ && rd_ack_i) line_q[word_q*DATA_W +: DATA_W] <= rd_rdata_i;
  end

  assign rd_req_o    = rd_req_q;
  assign rd_addr_o   = {fill_addr_i[ADDR_W-1:BYTE_OFS_W+WORD_OFS_W], word_q,
                        {BYTE_OFS_W{1'b0}}};
  assign fill_ack_o  = fill_ack_q;
  assign fill_line_o = line_q;
  assign fill_err_o  = err_q;

endmodule

`default_nettype wire

// File: hdl/rocache_route.sv
`timescale 1ns/1ns
`default_nettype none

module rocache_route (
  input  logic                                            clk_i,
  input  logic                                            rst_n_i,
  input  logic                                            enable_i,
  input  rocache_pkg::addr_t [rocache_pkg::NUM_RULES-1:0] rule_start_i,
  input  rocache_pkg::addr_t [rocache_pkg::NUM_RULES-1:0] rule_end_i,
  input  logic                                            cpu_req_i,
  input  logic                                            cpu_we_i,
  input  rocache_pkg::addr_t                              cpu_addr_i,
  input  rocache_pkg::data_t                              cpu_wdata_i,
  output logic                                            cpu_ack_o,
  output rocache_pkg::data_t                              cpu_rdata_o,
  output logic                                            cpu_err_o,
  output logic                                            cache_req_o,
  output rocache_pkg::addr_t                              cache_addr_o,
  input  logic                                            cache_ack_i,
  input  rocache_pkg::data_t                              cache_rdata_i,
  input  logic                                            cache_err_i,
  output logic                                            byp_req_o,
  output logic                                            byp_we_o,
  output rocache_pkg::addr_t                              byp_addr_o,
  output rocache_pkg::data_t                              byp_wdata_o,
  input  logic                                            byp_ack_i,
  input  rocache_pkg::data_t                              byp_rdata_i,
  input  logic                                            byp_err_i
);
  import rocache_pkg::*;

  path_e path_d;
  path_e path_q;
  logic  busy_q;
  // CPU has dropped its request
  logic  rel_q;
  logic  in_rule;
  logic  sel_ack;

  // Region match, only reads go to the cache
  always_comb begin
    in_rule = 1'b0;
    for (int i = 0; i < NUM_RULES; i++) begin
      if (cpu_addr_i >= rule_start_i[i] && cpu_addr_i < rule_end_i[i]) begin
        in_rule = 1'b1;
      end
    end
    path_d = (in_rule && enable_i && !cpu_we_i) ? PATH_CACHE : PATH_BYPASS;
  end

  // Path is sampled once and held until the downstream ack falls
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      busy_q <= 1'b0;
      rel_q  <= 1'b0;
      path_q <= PATH_BYPASS;
    end else if (!busy_q) begin
      if (cpu_req_i) begin
        busy_q <= 1'b1;
        path_q <= path_d;
      end
    end else if (!rel_q) begin
      if (!cpu_req_i) rel_q <= 1'b1;
    end else if (!sel_ack) begin
      busy_q <= 1'b0;
      rel_q  <= 1'b0;
    end
  end

  assign sel_ack      = (path_q == PATH_CACHE) ? cache_ack_i : byp_ack_i;
  assign cache_req_o  = busy_q && !rel_q && (path_q == PATH_CACHE);
  assign byp_req_o    = busy_q && !rel_q && (path_q == PATH_BYPASS);
  assign cache_addr_o = cpu_addr_i;
  assign byp_we_o     = cpu_we_i;
  assign byp_addr_o   = cpu_addr_i;
  assign byp_wdata_o  = cpu_wdata_i;

  assign cpu_ack_o   = busy_q && sel_ack;
  assign cpu_rdata_o = (path_q == PATH_CACHE) ? cache_rdata_i : byp_rdata_i;
  assign cpu_err_o   = (path_q == PATH_CACHE) ? cache_err_i : byp_err_i;

endmodule

`default_nettype wire

// File: hdl/rocache_top.sv
`timescale 1ns/1ns
`default_nettype none

module rocache_top (
  input  logic                                            clk_i,
  input  logic                                            rst_n_i,
  input  logic                                            cpu_req_i,
  input  logic                                            cpu_we_i,
  input  rocache_pkg::addr_t                              cpu_addr_i,
  input  rocache_pkg::data_t                              cpu_wdata_i,
  output logic                                            cpu_ack_o,
  output rocache_pkg::data_t                              cpu_rdata_o,
  output logic                                            cpu_err_o,
  output logic                                            mem_req_o,
  output logic                                            mem_we_o,
  output rocache_pkg::addr_t                              mem_addr_o,
  output rocache_pkg::data_t                              mem_wdata_o,
  input  logic                                            mem_ack_i,
  input  rocache_pkg::data_t                              mem_rdata_i,
  input  logic                                            mem_err_i,
  input  logic                                            enable_i,
  input  logic                                            flush_req_i,
  output logic                                            flush_ack_o,
  input  rocache_pkg::addr_t [rocache_pkg::NUM_RULES-1:0] rule_start_i,
  input  rocache_pkg::addr_t [rocache_pkg::NUM_RULES-1:0] rule_end_i
);
  import rocache_pkg::*;

  // Route to lookup
  logic  cache_req;
  addr_t cache_addr;
  logic  cache_ack;
  data_t cache_rdata;
  logic  cache_err;

  // Bypass client of the arbiter
  logic  byp_req;
  logic  byp_we;
  addr_t byp_addr;
  data_t byp_wdata;
  logic  byp_ack;
  data_t byp_rdata;
  logic  byp_err;

  // Lookup to refill
  logic  fill_req;
  addr_t fill_addr;
  logic  fill_ack;
  line_t fill_line;
  logic  fill_err;

  // Refill client of the arbiter
  logic  rd_req;
  addr_t rd_addr;
  logic  rd_ack;
  data_t rd_rdata;
  logic  rd_err;

  // ----------------------------------------------------------
  // Request routing
  // ----------------------------------------------------------
  rocache_route i_route (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .enable_i      (enable_i),
    .rule_start_i  (rule_start_i),
    .rule_end_i    (rule_end_i),
    .cpu_req_i     (cpu_req_i),
    .cpu_we_i      (cpu_we_i),
    .cpu_addr_i    (cpu_addr_i),
    .cpu_wdata_i   (cpu_wdata_i),
    .cpu_ack_o     (cpu_ack_o),
    .cpu_rdata_o   (cpu_rdata_o),
    .cpu_err_o     (cpu_err_o),
    .cache_req_o   (cache_req),
    .cache_addr_o  (cache_addr),
    .cache_ack_i   (cache_ack),
    .cache_rdata_i (cache_rdata),
    .cache_err_i   (cache_err),
    .byp_req_o     (byp_req),
    .byp_we_o      (byp_we),
    .byp_addr_o    (byp_addr),
    .byp_wdata_o   (byp_wdata),
    .byp_ack_i     (byp_ack),
    .byp_rdata_i   (byp_rdata),
    .byp_err_i     (byp_err)
  );

  // ----------------------------------------------------------
  // Cache arrays and line refill
  // ----------------------------------------------------------
  rocache_lookup i_lookup (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .flush_req_i   (flush_req_i),
    .flush_ack_o   (flush_ack_o),
    .cache_req_i   (cache_req),
    .cache_addr_i  (cache_addr),
    .cache_ack_o   (cache_ack),
    .cache_rdata_o (cache_rdata),
    .cache_err_o   (cache_err),
    .fill_req_o    (fill_req),
    .fill_addr_o   (fill_addr),
    .fill_ack_i    (fill_ack),
    .fill_line_i   (fill_line),
    .fill_err_i    (fill_err)
  );

  rocache_refill i_refill (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .fill_req_i  (fill_req),
    .fill_addr_i (fill_addr),
    .fill_ack_o  (fill_ack),
    .fill_line_o (fill_line),
    .fill_err_o  (fill_err),
    .rd_req_o    (rd_req),
    .rd_addr_o   (rd_addr),
    .rd_ack_i    (rd_ack),
    .rd_rdata_i  (rd_rdata),
    .rd_err_i    (rd_err)
  );

  // ----------------------------------------------------------
  // Memory port sharing
  // ----------------------------------------------------------
  rocache_mem_arb i_mem_arb (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .byp_req_i   (byp_req),
    .byp_we_i    (byp_we),
    .byp_addr_i  (byp_addr),
    .byp_wdata_i (byp_wdata),
    .byp_ack_o   (byp_ack),
    .byp_rdata_o (byp_rdata),
    .byp_err_o   (byp_err),
    .rd_req_i    (rd_req),
    .rd_addr_i   (rd_addr),
    .rd_ack_o    (rd_ack),
    .rd_rdata_o  (rd_rdata),
    .rd_err_o    (rd_err),
    .mem_req_o   (mem_req_o),
    .mem_we_o    (mem_we_o),
    .mem_addr_o  (mem_addr_o),
    .mem_wdata_o (mem_wdata_o),
    .mem_ack_i   (mem_ack_i),
    .mem_rdata_i (mem_rdata_i),
    .mem_err_i   (mem_err_i)
  );

endmodule

`default_nettype wire

// File: tb/rocache_assertions.sv
`timescale 1ns/1ns
`default_nettype none

module rocache_assertions (
  input logic               clk_i,
  input logic               rst_n_i,
  input logic               cpu_req_i,
  input logic               cpu_ack_i,
  input logic               mem_req_i,
  input rocache_pkg::addr_t mem_addr_i,
  input logic               flush_req_i,
  input logic               flush_ack_i
);
  int unsigned fail_count = 0;

  // No CPU ack out of a reset cycle
  ack_in_reset: assert property (@(posedge clk_i) !rst_n_i |=> !cpu_ack_i)
    else begin
      fail_count++;
      $error("cpu_ack_o high during reset");
    end

  // Ack rises only on a pending request
  ack_needs_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $rose(cpu_ack_i) |-> $past(cpu_req_i))
    else begin
      fail_count++;
      $error("cpu_ack_o rose without cpu_req_i");
    end

  mem_addr_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mem_req_i && $past(mem_req_i) |-> $stable(mem_addr_i))
    else begin
      fail_count++;
      $error("mem_addr_o changed while mem_req_o was high");
    end

  flush_ack_needs_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $rose(flush_ack_i) |-> $past(flush_req_i))
    else begin
      fail_count++;
      $error("flush_ack_o rose without flush_req_i");
    end

endmodule

`default_nettype wire

// File: tb/rocache_tb.sv
`timescale 1ns/1ns
`default_nettype none

module rocache_tb;
  import rocache_pkg::*;

  localparam int RESET_CYCLES    = 10;
  localparam int MAX_ACCESSES    = 300;
  localparam int ACCESS_CYCLES   = 60;
  localparam int WATCHDOG_CYCLES = RESET_CYCLES + MAX_ACCESSES * ACCESS_CYCLES;
  localparam int LINE_BYTES      = LINE_WORDS * (DATA_W / 8);
  localparam int MEM_WORDS       = 2 ** (ADDR_W - BYTE_OFS_W);

  logic                       clk = 1'b0;
  logic                       rst_n;
  logic                       cpu_req;
  logic                       cpu_we;
  addr_t                      cpu_addr;
  data_t                      cpu_wdata;
  logic                       cpu_ack;
  data_t                      cpu_rdata;
  logic                       cpu_err;
  logic                       mem_req;
  logic                       mem_we;
  addr_t                      mem_addr;
  data_t                      mem_wdata;
  logic                       mem_ack;
  data_t                      mem_rdata;
  logic                       mem_err;
  logic                       enable;
  logic                       flush_req;
  logic                       flush_ack;
  addr_t [NUM_RULES-1:0]      rule_start;
  addr_t [NUM_RULES-1:0]      rule_end;

  // Memory model state
  data_t wr_data [MEM_WORDS];
  bit    wr_valid [MEM_WORDS];
  addr_t err_lo;
  addr_t err_hi;
  int    rd_count;
  int    wr_count;
  addr_t last_wr_addr;
  data_t last_wr_data;

  // Reference model of the tag arrays
  bit    ref_valid [LINE_COUNT];
  tag_t  ref_tag [LINE_COUNT];
  data_t ref_line [LINE_COUNT][LINE_WORDS];

  int err_data;
  int err_cnt;
  int err_flag;
  int err_other;

  always #20 clk = ~clk;

  rocache_top i_rocache_top (
    .clk_i        (clk),
    .rst_n_i      (rst_n),
    .cpu_req_i    (cpu_req),
    .cpu_we_i     (cpu_we),
    .cpu_addr_i   (cpu_addr),
    .cpu_wdata_i  (cpu_wdata),
    .cpu_ack_o    (cpu_ack),
    .cpu_rdata_o  (cpu_rdata),
    .cpu_err_o    (cpu_err),
    .mem_req_o    (mem_req),
    .mem_we_o     (mem_we),
    .mem_addr_o   (mem_addr),
    .mem_wdata_o  (mem_wdata),
    .mem_ack_i    (mem_ack),
    .mem_rdata_i  (mem_rdata),
    .mem_err_i    (mem_err),
    .enable_i     (enable),
    .flush_req_i  (flush_req),
    .flush_ack_o  (flush_ack),
    .rule_start_i (rule_start),
    .rule_end_i   (rule_end)
  );

  bind rocache_top rocache_assertions i_assertions (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .cpu_req_i   (cpu_req_i),
    .cpu_ack_i   (cpu_ack_o),
    .mem_req_i   (mem_req_o),
    .mem_addr_i  (mem_addr_o),
    .flush_req_i (flush_req_i),
    .flush_ack_i (flush_ack_o)
  );

  // ----------------------------------------------------------
  // Memory contents and address rules
  // ----------------------------------------------------------
  function automatic data_t mem_value(input addr_t a);
    int unsigned w;
    w = a >> BYTE_OFS_W;
    if (wr_valid[w]) return wr_data[w];
    return data_t'(w) ^ 32'h5a5a_0000;
  endfunction

  function automatic bit in_err_window(input addr_t a);
    return (a >= err_lo) && (a < err_hi);
  endfunction

  function automatic bit line_has_err(input addr_t a);
    addr_t base;
    base = a & ~addr_t'(LINE_BYTES - 1);
    for (int k = 0; k < LINE_WORDS; k++) begin
      if (in_err_window(base + addr_t'(k * (DATA_W / 8)))) return 1'b1;
    end
    return 1'b0;
  endfunction

  function automatic bit is_cacheable(input addr_t a);
    bit hit_rule;
    hit_rule = 1'b0;
    for (int i = 0; i < NUM_RULES; i++) begin
      if (a >= rule_start[i] && a < rule_end[i]) hit_rule = 1'b1;
    end
    return hit_rule && enable;
  endfunction

  // Acks two cycles after req, drops ack once req is gone
  initial begin
    int wait_cnt;
    int unsigned w;
    mem_ack   = 1'b0;
    mem_rdata = '0;
    mem_err   = 1'b0;
    rd_count  = 0;
    wr_count  = 0;
    wait_cnt  = 0;
    forever begin
      @(negedge clk);
      if (!rst_n) begin
        mem_ack  = 1'b0;
        wait_cnt = 0;
      end else if (mem_req && !mem_ack) begin
        wait_cnt++;
        if (wait_cnt == 2) begin
          w = mem_addr >> BYTE_OFS_W;
          if (mem_we) begin
            wr_data[w]   = mem_wdata;
            wr_valid[w]  = 1'b1;
            last_wr_addr = mem_addr;
            last_wr_data = mem_wdata;
            mem_rdata    = '0;
            wr_count++;
          end else begin
            mem_rdata = mem_value(mem_addr);
            rd_count++;
          end
          mem_err = in_err_window(mem_addr);
          mem_ack = 1'b1;
        end
      end else if (!mem_req) begin
        mem_ack  = 1'b0;
        mem_err  = 1'b0;
        wait_cnt = 0;
      end
    end
  end

  // ----------------------------------------------------------
  // Compare tasks
  // ----------------------------------------------------------
  task automatic check_data(input string name, input data_t exp, input data_t act);
    if (act !== exp) begin
      err_data++;
      $display("error: time %0t signal %s expected %h actual %h", $time, name, exp, act);
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    if (act != exp) begin
      err_cnt++;
      $display("error: time %0t signal %s expected %0d actual %0d", $time, name, exp, act);
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      err_flag++;
      $display("error: time %0t signal %s expected %b actual %b", $time, name, exp, act);
    end
  endtask

  // ----------------------------------------------------------
  // Access tasks, entered and left on a falling edge
  // ----------------------------------------------------------
  task automatic cpu_access(input logic we, input addr_t addr, input data_t wdata,
                            output data_t rdata, output logic err, output int lat);
    int cycles;
    cpu_we    = we;
    cpu_addr  = addr;
    cpu_wdata = wdata;
    cpu_req   = 1'b1;
    cycles    = 0;
    // Ack and result sampled on the rising edge
    do begin
      @(posedge clk);
      cycles++;
    end while (!cpu_ack);
    rdata = cpu_rdata;
    err   = cpu_err;
    // First edge registers the request, ack is seen one edge after it rose
    lat   = cycles - 2;
    @(negedge clk);
    cpu_req = 1'b0;
    do begin
      @(posedge clk);
    end while (cpu_ack);
    @(negedge clk);
  endtask

  task automatic read_check(input addr_t addr);
    index_t    idx;
    tag_t      tag;
    word_ofs_t w;
    bit        cacheable;
    bit        exp_hit;
    logic      exp_err;
    data_t     exp_data;
    int        exp_reads;
    int        rd_before;
    data_t     rdata;
    logic      err;
    int        lat;
    addr_t     base;
    idx       = addr[BYTE_OFS_W+WORD_OFS_W +: INDEX_W];
    tag       = addr[ADDR_W-1 -: TAG_W];
    w         = addr[BYTE_OFS_W +: WORD_OFS_W];
    base      = addr & ~addr_t'(LINE_BYTES - 1);
    cacheable = is_cacheable(addr);
    exp_hit   = cacheable && ref_valid[idx] && (ref_tag[idx] == tag);
    exp_err   = 1'b0;
    if (exp_hit) begin
      exp_reads = 0;
      exp_data  = ref_line[idx][w];
    end else if (cacheable) begin
      exp_reads = LINE_WORDS;
      exp_err   = line_has_err(addr);
      exp_data  = mem_value(addr);
    end else begin
      exp_reads = 1;
      exp_err   = in_err_window(addr);
      exp_data  = mem_value(addr);
    end
    rd_before = rd_count;
    cpu_access(1'b0, addr, '0, rdata, err, lat);
    // A failed refill leaves the index invalid
    if (cacheable && !exp_hit) begin
      ref_valid[idx] = !exp_err;
      ref_tag[idx]   = tag;
      for (int k = 0; k < LINE_WORDS; k++) begin
        ref_line[idx][k] = mem_value(base + addr_t'(k * (DATA_W / 8)));
      end
    end
    check_flag("cpu_err_o", exp_err, err);
    if (!exp_err) check_data("cpu_rdata_o", exp_data, rdata);
    check_count("mem read count", rd_before + exp_reads, rd_count);
    if (exp_hit) check_count("hit latency", 2, lat);
  endtask

  task automatic write_check(input addr_t addr, input data_t data);
    int    rd_before;
    int    wr_before;
    data_t rdata;
    logic  err;
    int    lat;
    rd_before = rd_count;
    wr_before = wr_count;
    cpu_access(1'b1, addr, data, rdata, err, lat);
    check_count("mem write count", wr_before + 1, wr_count);
    check_count("mem read count", rd_before, rd_count);
    check_data("mem_addr_o", data_t'(addr), data_t'(last_wr_addr));
    check_data("mem_wdata_o", data, last_wr_data);
  endtask

  task automatic flush_check;
    int cycles;
    flush_req = 1'b1;
    cycles    = 0;
    while (!flush_ack) begin
      @(negedge clk);
      cycles++;
    end
    if (cycles < LINE_COUNT) begin
      err_other++;
      $display("error: flush finished after %0d cycles, before all %0d lines were swept",
               cycles, LINE_COUNT);
    end
    flush_req = 1'b0;
    while (flush_ack) @(negedge clk);
    @(negedge clk);
    for (int i = 0; i < LINE_COUNT; i++) ref_valid[i] = 1'b0;
  endtask

  // ----------------------------------------------------------
  // Directed tests
  // ----------------------------------------------------------
  task automatic test_miss_hit;
    read_check(16'h1000);
    read_check(16'h1008);
    read_check(16'h800c);
    read_check(16'h8004);
  endtask

  task automatic test_bypass;
    read_check(16'h4000);
    read_check(16'h4000);
    enable = 1'b0;
    read_check(16'h1000);
    read_check(16'h1000);
    enable = 1'b1;
    read_check(16'h1004);
  endtask

  // Cached copy of 0x1040 goes stale after the write
  task automatic test_writes;
    write_check(16'h4010, 32'hcafe_0001);
    read_check(16'h4010);
    read_check(16'h1040);
    write_check(16'h1040, 32'hcafe_0002);
    read_check(16'h1040);
    enable = 1'b0;
    read_check(16'h1040);
    enable = 1'b1;
  endtask

  task automatic test_flush;
    flush_check();
    read_check(16'h1040);
    read_check(16'h1000);
    read_check(16'h8004);
  endtask

  task automatic test_refill_error;
    err_lo = 16'h1200;
    err_hi = 16'h1208;
    read_check(16'h120c);
    read_check(16'h120c);
    enable = 1'b0;
    read_check(16'h1204);
    enable = 1'b1;
    err_lo = '0;
    err_hi = '0;
    read_check(16'h120c);
    read_check(16'h1200);
  endtask

  // Small spans so lines sharing an index evict each other
  task automatic test_random;
    int    region;
    addr_t addr;
    for (int i = 0; i < 200; i++) begin
      region = $urandom_range(2, 0);
      enable = ($urandom_range(3, 0) != 0);
      case (region)
        0:       addr = 16'h1000 + addr_t'($urandom_range(255, 0) << 2);
        1:       addr = 16'h8000 + addr_t'($urandom_range(127, 0) << 2);
        default: addr = 16'h4000 + addr_t'($urandom_range(63, 0) << 2);
      endcase
      read_check(addr);
    end
    enable = 1'b1;
  endtask

  task automatic print_counts;
    $display("errors: data %0d, count %0d, flag %0d, other %0d, assertion %0d",
             err_data, err_cnt, err_flag, err_other,
             i_rocache_top.i_assertions.fail_count);
  endtask

  // ----------------------------------------------------------
  // Watchdog and main sequence
  // ----------------------------------------------------------
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
    print_counts();
    $display("RESULT: FAIL");
    $finish;
  end

  initial begin
    int total;
    void'($urandom(32'h088a_0fd5));
    rst_n         = 1'b0;
    cpu_req       = 1'b0;
    cpu_we        = 1'b0;
    cpu_addr      = '0;
    cpu_wdata     = '0;
    enable        = 1'b1;
    flush_req     = 1'b0;
    rule_start[0] = 16'h1000;
    rule_end[0]   = 16'h1400;
    rule_start[1] = 16'h8000;
    rule_end[1]   = 16'h8200;
    err_lo        = '0;
    err_hi        = '0;
    err_data      = 0;
    err_cnt       = 0;
    err_flag      = 0;
    err_other     = 0;
    repeat (RESET_CYCLES) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    check_flag("cpu_ack_o", 1'b0, cpu_ack);
    check_flag("mem_req_o", 1'b0, mem_req);
    check_flag("flush_ack_o", 1'b0, flush_ack);

    test_miss_hit();
    test_bypass();
    test_writes();
    test_flush();
    test_refill_error();
    test_random();

    print_counts();
    total = err_data + err_cnt + err_flag + err_other +
            i_rocache_top.i_assertions.fail_count;
    if (total == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: vlog.f
hdl/rocache_pkg.sv
hdl/rocache_route.sv
hdl/rocache_lookup.sv
hdl/rocache_refill.sv
hdl/rocache_mem_arb.sv
hdl/rocache_top.sv
tb/rocache_assertions.sv
tb/rocache_tb.sv
